// File: src/periph_pkg.sv
// Address map and types shared by the APB peripheral block; at most 16 timers fit the timer region
package periph_pkg;

  localparam int AddrWidth = 12;
  localparam int DataWidth = 32;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;

  // ------------------------------------------------------------------------
  // Address map
  // ------------------------------------------------------------------------
  // Each region spans 0x100 bytes, each timer window 0x10 bytes
  localparam int RegionBits   = 8;
  localparam int TimerWinBits = 4;

  localparam addr_t TimerBase = 12'h000;
  localparam addr_t IrqBase   = 12'h100;

  // Timer window, bit 0 of ctrl is enable
  localparam logic [TimerWinBits-1:0] TimerCtrlOffs  = 4'h0;
  localparam logic [TimerWinBits-1:0] TimerCountOffs = 4'h4;
  localparam logic [TimerWinBits-1:0] TimerCmpOffs   = 4'h8;

  // Interrupt region
  localparam addr_t IrqPendingOffs = 12'h000;
  localparam addr_t IrqEnableOffs  = 12'h004;
  localparam addr_t IrqClaimOffs   = 12'h008;

  // ------------------------------------------------------------------------
  // Enums
  // ------------------------------------------------------------------------
  typedef enum logic [1:0] {
    REGION_TIMER,
    REGION_IRQ,
    REGION_NONE
  } region_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ_WAIT,
    ST_DONE
  } apb_state_e;

endpackage

// File: src/reg_bus_if.sv
// Single-cycle register bus; addr is the offset within a region, error is combinational
`timescale 1ns/1ns

interface reg_bus_if;

  logic              req;
  logic              we;
  periph_pkg::addr_t addr;
  periph_pkg::data_t wdata;
  periph_pkg::data_t rdata;
  logic              error;

  modport host (
    output req, we, addr, wdata,
    input  rdata, error
  );

  modport device (
    input  req, we, addr, wdata,
    output rdata, error
  );

endinterface

// File: src/apb_decoder.sv
// APB slave; writes finish in one access cycle, reads in two, unmapped space returns an error
`timescale 1ns/1ns

module apb_decoder (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  periph_pkg::addr_t paddr_i,
  input  periph_pkg::data_t pwdata_i,
  output periph_pkg::data_t prdata_o,
  output logic              pready_o,
  output logic              pslverr_o,
  reg_bus_if.host           timer_bus,
  reg_bus_if.host           irq_bus
);

  localparam int Hi = periph_pkg::AddrWidth - 1;
  localparam int Lo = periph_pkg::RegionBits;

  periph_pkg::apb_state_e state_q, state_d;
  periph_pkg::region_e    region;
  periph_pkg::addr_t      offset;
  periph_pkg::data_t      bus_rdata;
  periph_pkg::data_t      rdata_q;
  logic [Hi-Lo:0]         page;
  logic                   err_q;
  logic                   bus_err;
  logic                   access;
  logic                   bus_req;

  assign page   = paddr_i[Hi:Lo];
  assign offset = periph_pkg::addr_t'(paddr_i[Lo-1:0]);
  assign access = psel_i & penable_i;

  always_comb begin
    if (page == periph_pkg::TimerBase[Hi:Lo]) begin
      region = periph_pkg::REGION_TIMER;
    end else if (page == periph_pkg::IrqBase[Hi:Lo]) begin
      region = periph_pkg::REGION_IRQ;
    end else begin
      region = periph_pkg::REGION_NONE;
    end
  end

  // One request per transfer, write in first access cycle, read in READ_WAIT
  assign bus_req = access & (((state_q == periph_pkg::ST_IDLE) & pwrite_i) |
                             (state_q == periph_pkg::ST_READ_WAIT));

  assign timer_bus.req   = bus_req & (region == periph_pkg::REGION_TIMER);
  assign timer_bus.we    = pwrite_i;
  assign timer_bus.addr  = offset;
  assign timer_bus.wdata = pwdata_i;

  assign irq_bus.req   = bus_req & (region == periph_pkg::REGION_IRQ);
  assign irq_bus.we    = pwrite_i;
  assign irq_bus.addr  = offset;
  assign irq_bus.wdata = pwdata_i;

  always_comb begin
    case (region)
      periph_pkg::REGION_TIMER: begin
        bus_rdata = timer_bus.rdata;
        bus_err   = timer_bus.error;
      end
      periph_pkg::REGION_IRQ: begin
        bus_rdata = irq_bus.rdata;
        bus_err   = irq_bus.error;
      end
      default: begin
        bus_rdata = '0;
        bus_err   = 1'b1;
      end
    endcase
  end

  // ------------------------------------------------------------------------
  // Transfer FSM
  // ------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      periph_pkg::ST_IDLE: begin
        // Read seen in setup phase
        if (psel_i && !penable_i && !pwrite_i) begin
          state_d = periph_pkg::ST_READ_WAIT;
        end
      end
      periph_pkg::ST_READ_WAIT: begin
        if (access) begin
          state_d = periph_pkg::ST_DONE;
        end
      end
      default: state_d = periph_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= periph_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Read response held for the completing cycle
  always_ff @(posedge clk_i) begin
    if (state_q == periph_pkg::ST_READ_WAIT && access) begin
      rdata_q <= bus_rdata;
      err_q   <= bus_err;
    end
  end

  assign pready_o  = access & ((state_q == periph_pkg::ST_DONE) |
                               ((state_q == periph_pkg::ST_IDLE) & pwrite_i));
  assign pslverr_o = pready_o & ((state_q == periph_pkg::ST_DONE) ? err_q : bus_err);
  assign prdata_o  = (access && state_q == periph_pkg::ST_DONE) ? rdata_q : '0;

endmodule

// File: src/timer_unit.sv
// Compare timers in 0x10-byte windows; the event is combinational and lasts the reload cycle
`timescale 1ns/1ns

module timer_unit #(
  parameter int NumTimers = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  reg_bus_if.device            bus,
  output logic [NumTimers-1:0] timer_evt_o
);

  localparam int WinBits = periph_pkg::TimerWinBits;
  localparam int RegBits = periph_pkg::RegionBits;
  localparam int Hi      = periph_pkg::AddrWidth - 1;

  logic                 en_q    [NumTimers];
  periph_pkg::data_t    count_q [NumTimers];
  periph_pkg::data_t    cmp_q   [NumTimers];
  logic [NumTimers-1:0] sel;
  logic [WinBits-1:0]   reg_offs;
  logic                 in_region;
  logic                 wr;

  assign reg_offs  = bus.addr[WinBits-1:0];
  assign in_region = (bus.addr[Hi:RegBits] == '0);
  assign wr        = bus.req & bus.we & in_region;

  for (genvar i = 0; i < NumTimers; i++) begin : gen_timer
    assign sel[i] = (bus.addr[RegBits-1:WinBits] == (RegBits - WinBits)'(i));

    // Expiry at count == cmp, reload to zero on the same edge
    assign timer_evt_o[i] = en_q[i] & (count_q[i] == cmp_q[i]);

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        en_q[i]    <= 1'b0;
        count_q[i] <= '0;
        cmp_q[i]   <= '0;
      end else begin
        if (wr && sel[i] && reg_offs == periph_pkg::TimerCtrlOffs) begin
          en_q[i] <= bus.wdata[0];
        end
        if (wr && sel[i] && reg_offs == periph_pkg::TimerCmpOffs) begin
          cmp_q[i] <= bus.wdata;
        end
        // Software write overrides counting
        if (wr && sel[i] && reg_offs == periph_pkg::TimerCountOffs) begin
          count_q[i] <= bus.wdata;
        end else if (timer_evt_o[i]) begin
          count_q[i] <= '0;
        end else if (en_q[i]) begin
          count_q[i] <= count_q[i] + 1'b1;
        end
      end
    end
  end

  // ------------------------------------------------------------------------
  // Read mux and decode error
  // ------------------------------------------------------------------------
  always_comb begin
    bus.rdata = '0;
    bus.error = 1'b1;
    for (int i = 0; i < NumTimers; i++) begin
      if (sel[i] && in_region) begin
        case (reg_offs)
          periph_pkg::TimerCtrlOffs: begin
            bus.rdata = periph_pkg::data_t'(en_q[i]);
            bus.error = 1'b0;
          end
          periph_pkg::TimerCountOffs: begin
            bus.rdata = count_q[i];
            bus.error = 1'b0;
          end
          periph_pkg::TimerCmpOffs: begin
            bus.rdata = cmp_q[i];
            bus.error = 1'b0;
          end
          default: bus.error = 1'b1;
        endcase
      end
    end
  end

endmodule

// File: src/irq_controller.sv
// Level-sampled sources with one target; lowest index wins, claim clears on the bus read edge
`timescale 1ns/1ns

module irq_controller #(
  parameter int NumTimers = 2,
  parameter int NumExtIrq = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic [NumTimers-1:0] timer_evt_i,
  input  logic [NumExtIrq-1:0] ext_irq_i,
  reg_bus_if.device            bus,
  output logic                 irq_o
);

  localparam int NumSrc = NumTimers + NumExtIrq;

  logic [NumSrc-1:0] src;
  logic [NumSrc-1:0] pending_q;
  logic [NumSrc-1:0] enable_q;
  logic [NumSrc-1:0] active;
  logic [NumSrc-1:0] claim_mask;
  periph_pkg::data_t claim_id;
  logic              claim_rd;
  logic              enable_wr;

  assign src    = {ext_irq_i, timer_evt_i};
  assign active = pending_q & enable_q;
  assign irq_o  = |active;

  // Isolate lowest set bit
  assign claim_mask = active & (~active + 1'b1);

  always_comb begin
    claim_id = '0;
    for (int i = NumSrc - 1; i >= 0; i--) begin
      if (active[i]) begin
        claim_id = periph_pkg::data_t'(i + 1);
      end
    end
  end

  assign enable_wr = bus.req & bus.we & (bus.addr == periph_pkg::IrqEnableOffs);
  assign claim_rd  = bus.req & ~bus.we & (bus.addr == periph_pkg::IrqClaimOffs);

  // ------------------------------------------------------------------------
  // Pending and enable registers
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q <= '0;
      enable_q  <= '0;
    end else begin
      // New source activity beats a simultaneous claim
      pending_q <= (pending_q & ~({NumSrc{claim_rd}} & claim_mask)) | src;
      if (enable_wr) begin
        enable_q <= bus.wdata[NumSrc-1:0];
      end
    end
  end

  always_comb begin
    bus.rdata = '0;
    bus.error = 1'b0;
    case (bus.addr)
      periph_pkg::IrqPendingOffs: begin
        bus.rdata = periph_pkg::data_t'(pending_q);
        bus.error = bus.we;
      end
      periph_pkg::IrqEnableOffs: begin
        bus.rdata = periph_pkg::data_t'(enable_q);
      end
      periph_pkg::IrqClaimOffs: begin
        bus.rdata = claim_id;
        bus.error = bus.we;
      end
      default: bus.error = 1'b1;
    endcase
  end

endmodule

// File: src/apb_periph_top.sv
// APB slave with timers and an interrupt controller; NumTimers + NumExtIrq must fit DataWidth
`timescale 1ns/1ns

module apb_periph_top #(
  parameter int NumTimers = 2,
  parameter int NumExtIrq = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 psel_i,
  input  logic                 penable_i,
  input  logic                 pwrite_i,
  input  periph_pkg::addr_t    paddr_i,
  input  periph_pkg::data_t    pwdata_i,
  input  logic [NumExtIrq-1:0] ext_irq_i,
  output periph_pkg::data_t    prdata_o,
  output logic                 pready_o,
  output logic                 pslverr_o,
  output logic                 irq_o
);

  localparam int MaxTimers = 1 << (periph_pkg::RegionBits - periph_pkg::TimerWinBits);

  if ((NumTimers + NumExtIrq > periph_pkg::DataWidth) ||
      (NumTimers > MaxTimers)) begin : gen_param_check
    $error("Too many interrupt sources or timers for the register map");
  end

  reg_bus_if timer_bus ();
  reg_bus_if irq_bus ();

  logic [NumTimers-1:0] timer_evt;

  // ------------------------------------------------------------------------
  // APB front end
  // ------------------------------------------------------------------------
  apb_decoder i_apb_decoder (
    .clk_i     ( clk_i     ),
    .rst_i     ( rst_i     ),
    .psel_i    ( psel_i    ),
    .penable_i ( penable_i ),
    .pwrite_i  ( pwrite_i  ),
    .paddr_i   ( paddr_i   ),
    .pwdata_i  ( pwdata_i  ),
    .prdata_o  ( prdata_o  ),
    .pready_o  ( pready_o  ),
    .pslverr_o ( pslverr_o ),
    .timer_bus ( timer_bus ),
    .irq_bus   ( irq_bus   )
  );

  // ------------------------------------------------------------------------
  // Timers and interrupt controller
  // ------------------------------------------------------------------------
  timer_unit #(
    .NumTimers ( NumTimers )
  ) i_timer_unit (
    .clk_i       ( clk_i     ),
    .rst_i       ( rst_i     ),
    .bus         ( timer_bus ),
    .timer_evt_o ( timer_evt )
  );

  // Timer events take the low source indices, external lines sit above
  irq_controller #(
    .NumTimers ( NumTimers ),
    .NumExtIrq ( NumExtIrq )
  ) i_irq_controller (
    .clk_i       ( clk_i     ),
    .rst_i       ( rst_i     ),
    .timer_evt_i ( timer_evt ),
    .ext_irq_i   ( ext_irq_i ),
    .bus         ( irq_bus   ),
    .irq_o       ( irq_o     )
  );

endmodule

// File: verification/apb_periph_sva.sv
// APB handshake checks sampled on the rising edge; assumes the master keeps psel_i low in reset
`timescale 1ns/1ns

module apb_periph_sva (
  input logic clk_i,
  input logic rst_i,
  input logic psel_i,
  input logic penable_i,
  input logic pready_o,
  input logic pslverr_o,
  input logic irq_o
);

  int fail_count;

  // Ready only in the access phase
  ready_in_access: assert property (@(posedge clk_i) disable iff (rst_i)
    pready_o |-> (psel_i && penable_i))
    else begin
      $error("pready_o high outside an access phase");
      fail_count++;
    end

  slverr_with_ready: assert property (@(posedge clk_i) disable iff (rst_i)
    pslverr_o |-> pready_o)
    else begin
      $error("pslverr_o high without pready_o");
      fail_count++;
    end

  // First cycle out of reset
  quiet_after_reset: assert property (@(posedge clk_i)
    (rst_i ##1 !rst_i) |-> (!pready_o && !pslverr_o && !irq_o))
    else begin
      $error("pready_o, pslverr_o or irq_o high right after reset");
      fail_count++;
    end

endmodule

bind apb_periph_top apb_periph_sva i_apb_periph_sva (
  .clk_i     ( clk_i     ),
  .rst_i     ( rst_i     ),
  .psel_i    ( psel_i    ),
  .penable_i ( penable_i ),
  .pready_o  ( pready_o  ),
  .pslverr_o ( pslverr_o ),
  .irq_o     ( irq_o     )
);

// File: verification/tb_apb_periph.sv
// Runs the DUT with default parameters (2 timers, 2 external lines); stops at the first bad check
`timescale 1ns/1ns

module tb_apb_periph;

  localparam int NumTimers = 2;
  localparam int NumExtIrq = 2;
  localparam int NumSrc    = NumTimers + NumExtIrq;
  localparam int ClkPeriod = 8;
  localparam int MaxWait   = 8;
  localparam int TimerCmp  = 5;
  localparam int MaskedCmp = 3;
  localparam int RandIter  = 8;

  // Setup, up to two access cycles and one idle cycle per transfer
  localparam int AccessCycles = 5;
  localparam int NumAccesses  = 9 + 20 + 8 + 14 + 10 + RandIter * (3 + NumExtIrq) + 8;
  localparam int WaitCycles   = TimerCmp + MaskedCmp + 3 + RandIter * 2 + 4;
  localparam int WatchdogNs   = (8 + NumAccesses * AccessCycles + WaitCycles + 100) * ClkPeriod;

  localparam logic [NumSrc-1:0] AllSrc = '1;
  localparam logic [NumSrc-1:0] ExtSrc = AllSrc << NumTimers;

  logic                 clk_i;
  logic                 rst_i;
  logic                 psel_i;
  logic                 penable_i;
  logic                 pwrite_i;
  periph_pkg::addr_t    paddr_i;
  periph_pkg::data_t    pwdata_i;
  logic [NumExtIrq-1:0] ext_irq_i;
  periph_pkg::data_t    prdata_o;
  logic                 pready_o;
  logic                 pslverr_o;
  logic                 irq_o;

  logic [31:0]          rng_state;
  logic [NumSrc-1:0]    exp_pending;
  logic [NumSrc-1:0]    exp_enable;
  periph_pkg::data_t    val_a;
  periph_pkg::data_t    val_b;

  apb_periph_top UUT (
    .clk_i     ( clk_i     ),
    .rst_i     ( rst_i     ),
    .psel_i    ( psel_i    ),
    .penable_i ( penable_i ),
    .pwrite_i  ( pwrite_i  ),
    .paddr_i   ( paddr_i   ),
    .pwdata_i  ( pwdata_i  ),
    .ext_irq_i ( ext_irq_i ),
    .prdata_o  ( prdata_o  ),
    .pready_o  ( pready_o  ),
    .pslverr_o ( pslverr_o ),
    .irq_o     ( irq_o     )
  );

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  task automatic report_failure();
    $display("Finished with errors");
    $fatal(1, "Stopped at the first failed check");
  endtask

  task automatic expect_equal(input string name, input periph_pkg::data_t expected,
                              input periph_pkg::data_t actual);
    assert (actual === expected) else begin
      $display("** Error: %s expected 0x%h, got 0x%h", name, expected, actual);
      report_failure();
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic periph_pkg::addr_t timer_addr(input int idx, input logic [3:0] offs);
    return periph_pkg::TimerBase + periph_pkg::addr_t'(idx << periph_pkg::TimerWinBits) +
           periph_pkg::addr_t'(offs);
  endfunction

  function automatic periph_pkg::addr_t irq_addr(input periph_pkg::addr_t offs);
    return periph_pkg::IrqBase + offs;
  endfunction

  // Lowest pending and enabled source, counted from one
  function automatic periph_pkg::data_t expected_claim(input logic [NumSrc-1:0] pend,
                                                       input logic [NumSrc-1:0] en);
    periph_pkg::data_t id;
    logic              found;
    id    = '0;
    found = 1'b0;
    for (int i = 0; i < NumSrc; i++) begin
      if (!found && pend[i] && en[i]) begin
        id    = periph_pkg::data_t'(i + 1);
        found = 1'b1;
      end
    end
    return id;
  endfunction

  task automatic run_transfer(input logic is_write, input periph_pkg::addr_t addr,
                              input periph_pkg::data_t wdata,
                              output periph_pkg::data_t rdata, output logic err,
                              output int cycles);
    logic done;
    cycles = 0;
    done   = 1'b0;
    rdata  = '0;
    err    = 1'b0;
    @(negedge clk_i);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = is_write;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(negedge clk_i);
    penable_i = 1'b1;
    while (!done) begin
      @(posedge clk_i);
      cycles++;
      if (pready_o) begin
        done  = 1'b1;
        rdata = prdata_o;
        err   = pslverr_o;
      end else if (cycles >= MaxWait) begin
        $display("pready_o stayed low for %0d access cycles at address 0x%h", cycles, addr);
        report_failure();
      end
    end
    @(negedge clk_i);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic apb_write(input periph_pkg::addr_t addr, input periph_pkg::data_t wdata,
                           input logic exp_err);
    periph_pkg::data_t rdata;
    logic              err;
    int                cycles;
    run_transfer(1'b1, addr, wdata, rdata, err, cycles);
    expect_equal($sformatf("write access cycles at 0x%h", addr), 1, cycles);
    expect_equal($sformatf("pslverr_o on write at 0x%h", addr), exp_err, err);
  endtask

  task automatic apb_read(input periph_pkg::addr_t addr, input periph_pkg::data_t exp_data,
                          input logic exp_err);
    periph_pkg::data_t rdata;
    logic              err;
    int                cycles;
    run_transfer(1'b0, addr, '0, rdata, err, cycles);
    expect_equal($sformatf("read access cycles at 0x%h", addr), 2, cycles);
    expect_equal($sformatf("pslverr_o on read at 0x%h", addr), exp_err, err);
    expect_equal($sformatf("prdata_o at 0x%h", addr), exp_data, rdata);
  endtask

  task automatic drain_claims();
    periph_pkg::data_t id;
    id = expected_claim(exp_pending, exp_enable);
    while (id != 0) begin
      apb_read(irq_addr(periph_pkg::IrqClaimOffs), id, 1'b0);
      exp_pending[id - 1] = 1'b0;
      expect_equal("irq_o after claim", |(exp_pending & exp_enable), irq_o);
      id = expected_claim(exp_pending, exp_enable);
    end
    apb_read(irq_addr(periph_pkg::IrqClaimOffs), '0, 1'b0);
  endtask

  // --------------------------------------------------------------------------
  // Clock, watchdog and test sequence
  // --------------------------------------------------------------------------
  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin
    #(WatchdogNs);
    $display("Timeout: the tests did not finish within %0d ns", WatchdogNs);
    report_failure();
  end

  // Bound protocol checker
  initial begin
    wait (UUT.i_apb_periph_sva.fail_count != 0);
    $display("A bound APB protocol assertion failed");
    report_failure();
  end

  initial begin
    rst_i       = 1'b1;
    psel_i      = 1'b0;
    penable_i   = 1'b0;
    pwrite_i    = 1'b0;
    paddr_i     = '0;
    pwdata_i    = '0;
    ext_irq_i   = '0;
    rng_state   = 32'd56419;
    exp_pending = '0;
    exp_enable  = '0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    // Quiet outputs and zero registers out of reset
    expect_equal("pready_o after reset", 0, pready_o);
    expect_equal("pslverr_o after reset", 0, pslverr_o);
    expect_equal("irq_o after reset", 0, irq_o);
    for (int i = 0; i < NumTimers; i++) begin
      apb_read(timer_addr(i, periph_pkg::TimerCtrlOffs), '0, 1'b0);
      apb_read(timer_addr(i, periph_pkg::TimerCountOffs), '0, 1'b0);
      apb_read(timer_addr(i, periph_pkg::TimerCmpOffs), '0, 1'b0);
    end
    apb_read(irq_addr(periph_pkg::IrqPendingOffs), '0, 1'b0);
    apb_read(irq_addr(periph_pkg::IrqEnableOffs), '0, 1'b0);
    apb_read(irq_addr(periph_pkg::IrqClaimOffs), '0, 1'b0);

    // Register read back
    for (int i = 0; i < NumTimers; i++) begin
      rng_state = xorshift32(rng_state);
      val_a     = rng_state;
      rng_state = xorshift32(rng_state);
      val_b     = rng_state;
      apb_write(timer_addr(i, periph_pkg::TimerCountOffs), val_a, 1'b0);
      apb_write(timer_addr(i, periph_pkg::TimerCmpOffs), val_b, 1'b0);
      apb_read(timer_addr(i, periph_pkg::TimerCountOffs), val_a, 1'b0);
      apb_read(timer_addr(i, periph_pkg::TimerCmpOffs), val_b, 1'b0);
      apb_write(timer_addr(i, periph_pkg::TimerCountOffs), '0, 1'b0);
      apb_write(timer_addr(i, periph_pkg::TimerCmpOffs), '0, 1'b0);
    end
    rng_state = xorshift32(rng_state);
    apb_write(irq_addr(periph_pkg::IrqEnableOffs), rng_state, 1'b0);
    apb_read(irq_addr(periph_pkg::IrqEnableOffs), rng_state[NumSrc-1:0], 1'b0);
    apb_write(irq_addr(periph_pkg::IrqEnableOffs), '0, 1'b0);

    // Unmapped space and read-only or undefined registers
    apb_read(12'h200, '0, 1'b1);
    apb_read(12'hffc, '0, 1'b1);
    apb_write(12'h3f0, rng_state, 1'b1);
    apb_write(irq_addr(periph_pkg::IrqPendingOffs), rng_state, 1'b1);
    apb_write(irq_addr(periph_pkg::IrqClaimOffs), rng_state, 1'b1);
    apb_read(irq_addr(12'h00c), '0, 1'b1);
    apb_read(timer_addr(0, 4'hc), '0, 1'b1);
    apb_read(timer_addr(NumTimers, periph_pkg::TimerCtrlOffs), '0, 1'b1);
    expect_equal("irq_o after error accesses", 0, irq_o);

    // Timer 0 enabled in the mask, fires cmp+1 cycles after start
    exp_enable = NumSrc'(1);
    apb_write(irq_addr(periph_pkg::IrqEnableOffs), exp_enable, 1'b0);
    apb_write(timer_addr(0, periph_pkg::TimerCmpOffs), TimerCmp, 1'b0);
    apb_write(timer_addr(0, periph_pkg::TimerCtrlOffs), 1, 1'b0);
    expect_equal("irq_o at timer 0 start", 0, irq_o);
    for (int k = 1; k <= TimerCmp + 1; k++) begin
      @(negedge clk_i);
      expect_equal($sformatf("irq_o %0d cycles after timer 0 start", k),
                   (k == TimerCmp + 1), irq_o);
    end
    exp_pending[0] = 1'b1;
    apb_write(timer_addr(0, periph_pkg::TimerCtrlOffs), 0, 1'b0);
    apb_read(irq_addr(periph_pkg::IrqPendingOffs), exp_pending, 1'b0);
    drain_claims();

    // Timer 1 masked
    apb_write(timer_addr(1, periph_pkg::TimerCmpOffs), MaskedCmp, 1'b0);
    apb_write(timer_addr(1, periph_pkg::TimerCtrlOffs), 1, 1'b0);
    for (int k = 1; k <= MaskedCmp + 2; k++) begin
      @(negedge clk_i);
      expect_equal($sformatf("irq_o %0d cycles after masked timer 1 start", k), 0, irq_o);
    end
    exp_pending[1] = 1'b1;
    apb_write(timer_addr(1, periph_pkg::TimerCtrlOffs), 0, 1'b0);
    apb_read(irq_addr(periph_pkg::IrqPendingOffs), exp_pending, 1'b0);
    drain_claims();

    // Several sources, claimed lowest first
    @(negedge clk_i);
    ext_irq_i = '1;
    @(negedge clk_i);
    ext_irq_i   = '0;
    exp_pending = exp_pending | ExtSrc;
    exp_enable  = AllSrc;
    apb_write(irq_addr(periph_pkg::IrqEnableOffs), exp_enable, 1'b0);
    expect_equal("irq_o with all sources enabled", 1, irq_o);
    drain_claims();

    // Random external patterns
    exp_enable = ExtSrc;
    apb_write(irq_addr(periph_pkg::IrqEnableOffs), exp_enable, 1'b0);
    for (int n = 0; n < RandIter; n++) begin
      rng_state = xorshift32(rng_state);
      @(negedge clk_i);
      ext_irq_i = rng_state[NumExtIrq-1:0];
      @(negedge clk_i);
      ext_irq_i   = '0;
      exp_pending = exp_pending | (NumSrc'(rng_state[NumExtIrq-1:0]) << NumTimers);
      apb_read(irq_addr(periph_pkg::IrqPendingOffs), exp_pending, 1'b0);
      drain_claims();
      apb_read(irq_addr(periph_pkg::IrqPendingOffs), '0, 1'b0);
    end

    // Source held active across a claim
    @(negedge clk_i);
    ext_irq_i            = NumExtIrq'(1);
    exp_pending[NumTimers] = 1'b1;
    apb_read(irq_addr(periph_pkg::IrqClaimOffs), NumTimers + 1, 1'b0);
    apb_read(irq_addr(periph_pkg::IrqPendingOffs), exp_pending, 1'b0);
    @(negedge clk_i);
    ext_irq_i = '0;
    drain_claims();
    apb_read(irq_addr(periph_pkg::IrqPendingOffs), '0, 1'b0);
    expect_equal("irq_o at end", 0, irq_o);

    if (UUT.i_apb_periph_sva.fail_count != 0) begin
      $display("A bound APB protocol assertion failed");
      report_failure();
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

// File: compile.f
src/periph_pkg.sv
src/reg_bus_if.sv
src/apb_decoder.sv
src/timer_unit.sv
src/irq_controller.sv
src/apb_periph_top.sv
verification/apb_periph_sva.sv
verification/tb_apb_periph.sv
